/* dv/axis_width_chain_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_width_chain_assert
  import stream_pkg::*, adapter_pkg::*;
(
  input wire                 clk,
  input wire                 rst,
  input wire out_data_t      m_axis_tdata,
  input wire out_keep_t      m_axis_tkeep,
  input wire                 m_axis_tvalid,
  input wire                 m_axis_tready,
  input wire                 m_axis_tlast,
  input wire                 m_axis_tuser,
  input wire adapter_state_t widen_state
);

  int unsigned failures = 0;  // read by the testbench for its final verdict

  // a stalled beat must sit still until the sink takes it
  assert property (@(posedge clk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tkeep) && $stable(m_axis_tlast) && $stable(m_axis_tuser))
    else begin
      failures++;
      $error("output beat changed or dropped while stalled");
    end

  assert property (@(posedge clk) disable iff (rst)
    m_axis_tvalid |-> m_axis_tkeep != '0 && (m_axis_tkeep & (m_axis_tkeep + 1'b1)) == '0)
    else begin
      failures++;
      $error("output keep is not contiguous from lane 0");
    end

  assert property (@(posedge clk) disable iff (rst)
    m_axis_tvalid && !m_axis_tlast |-> m_axis_tkeep == '1)
    else begin
      failures++;
      $error("output keep is partial on a beat that is not last");
    end

  assert property (@(posedge clk) disable iff (rst)
    widen_state inside {idle, transfer_in, transfer_out})  // the unused fourth encoding
    else begin
      failures++;
      $error("widening adapter reached an invalid state");
    end

endmodule

`default_nettype wire

/* dv/tb_axis_width_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axis_width_chain
  import stream_pkg::*;
();

  localparam int PERIOD        = 8;
  localparam int RESET_CYCLES  = 4;
  localparam int RANDOM_FRAMES = 20;

  typedef byte_t byte_q_t[$];

  logic      clk;
  logic      rst;
  in_data_t  s_axis_tdata;
  in_keep_t  s_axis_tkeep;
  logic      s_axis_tvalid, s_axis_tready, s_axis_tlast, s_axis_tuser;
  out_data_t m_axis_tdata;
  out_keep_t m_axis_tkeep;
  logic      m_axis_tvalid, m_axis_tready, m_axis_tlast, m_axis_tuser;

  // expected output words, one entry per beat
  out_data_t   exp_data[$];
  out_keep_t   exp_keep[$];
  bit          exp_last[$];
  bit          exp_user[$];

  string       cur_test;
  int          errors, test_errors, pass_count, fail_count;
  int unsigned cycle_count = 0;
  int unsigned test_start, cycle_limit;
  bit          random_ready, saw_full_stall;

  axis_width_chain u_axis_width_chain (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tuser  (s_axis_tuser),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser)
  );

  bind axis_width_chain axis_width_chain_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser),
    .widen_state   (u_widen.state_reg)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // sink side, random stalls only while the back-pressure test runs
  initial begin
    m_axis_tready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      m_axis_tready = random_ready ? ($urandom % 4 == 0) : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count - test_start > cycle_limit) begin
      $display("timeout in %s, no progress within %0d cycles", cur_test, cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string what, input out_data_t exp, input out_data_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_keep(input string what, input out_keep_t exp, input out_keep_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input bit exp, input bit act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  function automatic out_data_t keep_mask(input out_keep_t keep);
    out_data_t mask;
    int        l;
    mask = '0;
    for (l = 0; l < OUT_BYTES; l++) begin
      if (keep[l]) mask[l*8 +: 8] = 8'hff;
    end
    return mask;
  endfunction

  // outputs are registered, so the negative edge sees what the next rising edge takes
  always @(negedge clk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_data.size() == 0) begin
        $display("%s: output beat arrived with no word left to match", cur_test);
        errors++;
      end else begin
        check_keep("tkeep", exp_keep[0], m_axis_tkeep);
        check_data("tdata", exp_data[0], m_axis_tdata & keep_mask(exp_keep[0]));
        check_flag("tlast", exp_last[0], m_axis_tlast);
        check_flag("tuser", exp_user[0], m_axis_tuser);
        void'(exp_data.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
        void'(exp_user.pop_front());
      end
    end
    if (!rst && u_axis_width_chain.u_buffer.full && !s_axis_tready) saw_full_stall = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // stimulus and byte model
  ////////////////////////////////////////////////////////////

  function automatic byte_q_t pattern_bytes(input int len, input int base);
    byte_q_t q;
    int      i;
    for (i = 0; i < len; i++) begin
      q.push_back(byte_t'(base + i));
    end
    return q;
  endfunction

  // packs bytes from lane 0, the frame's last word may be partial and carries user
  task automatic expect_frame(input byte_q_t bytes, input bit user);
    out_data_t data;
    out_keep_t keep;
    int        i, l;
    for (i = 0; i < bytes.size(); i += OUT_BYTES) begin
      data = '0;
      keep = '0;
      for (l = 0; l < OUT_BYTES; l++) begin
        if (i + l < bytes.size()) begin
          data[l*8 +: 8] = bytes[i+l];
          keep[l]        = 1'b1;
        end
      end
      exp_data.push_back(data);
      exp_keep.push_back(keep);
      exp_last.push_back(i + OUT_BYTES >= bytes.size());
      exp_user.push_back(user && i + OUT_BYTES >= bytes.size());
    end
  endtask

  task automatic send_frame(input byte_q_t bytes, input bit user);
    int n, w, l;
    bit taken;
    n = bytes.size();
    for (w = 0; w < n; w += IN_BYTES) begin
      s_axis_tdata = '0;
      s_axis_tkeep = '0;
      for (l = 0; l < IN_BYTES; l++) begin
        if (w + l < n) begin
          s_axis_tdata[l*8 +: 8] = bytes[w+l];
          s_axis_tkeep[l]        = 1'b1;
        end
      end
      s_axis_tlast  = w + IN_BYTES >= n;
      s_axis_tuser  = user && w + IN_BYTES >= n;
      s_axis_tvalid = 1'b1;
      do begin
        @(negedge clk);
        taken = s_axis_tready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    s_axis_tuser  = 1'b0;
  endtask

  task automatic run_frame(input byte_q_t bytes, input bit user);
    expect_frame(bytes, user);
    send_frame(bytes, user);
  endtask

  task automatic start_test(input string name, input int unsigned nbytes);
    cur_test    = name;
    test_start  = cycle_count;
    cycle_limit = 20 * nbytes + 200;
    test_errors = errors;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // room for a stray extra beat to show up
    #1;
  endtask

  task automatic report_test();
    if (errors == test_errors) begin
      pass_count++;
      $display("%s: ok", cur_test);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", cur_test, errors - test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int n;
    start_test("reset", 0);
    check_flag("tvalid after reset", 1'b0, m_axis_tvalid);
    n = 0;
    while (!s_axis_tready && n < 5) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!s_axis_tready) begin
      $display("%s: s_axis_tready stayed low after reset", cur_test);
      errors++;
    end
    wait_drain();
    report_test();
  endtask

  task automatic test_full_words();
    int f;
    start_test("full_words", 24);
    for (f = 0; f < 3; f++) begin
      run_frame(pattern_bytes(8, f * 16), 1'b0);
    end
    wait_drain();
    report_test();
  endtask

  task automatic test_partial_last();
    int len;
    start_test("partial_last", 18);
    for (len = 5; len <= 7; len++) begin
      run_frame(pattern_bytes(len, len * 32), 1'b0);
    end
    wait_drain();
    report_test();
  endtask

  task automatic test_user_flag();
    start_test("user_flag", 13);
    run_frame(pattern_bytes(6, 8'h60), 1'b1);  // bad frame
    run_frame(pattern_bytes(7, 8'h70), 1'b0);
    wait_drain();
    report_test();
  endtask

  task automatic test_backpressure();
    byte_q_t     frames[RANDOM_FRAMES];
    bit          users[RANDOM_FRAMES];
    int unsigned total, len;
    int          f, i;
    total = 0;
    for (f = 0; f < RANDOM_FRAMES; f++) begin
      len = 1 + $urandom % 24;
      for (i = 0; i < len; i++) begin
        frames[f].push_back(byte_t'($urandom));
      end
      users[f] = 1'($urandom % 2);
      total += len;
    end
    start_test("backpressure", total);
    saw_full_stall = 1'b0;
    random_ready   = 1'b1;
    for (f = 0; f < RANDOM_FRAMES; f++) begin
      run_frame(frames[f], users[f]);
    end
    wait_drain();
    random_ready = 1'b0;
    if (!saw_full_stall) begin
      $display("%s: the FIFO never filled with s_axis_tready low", cur_test);
      errors++;
    end
    report_test();
  endtask

  initial begin
    void'($urandom(90));
    rst           = 1'b1;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    s_axis_tuser  = 1'b0;
    random_ready  = 1'b0;
    cur_test      = "reset";
    test_start    = 0;
    cycle_limit   = 200;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_full_words();
    test_partial_last();
    test_user_flag();
    test_backpressure();
    if (u_axis_width_chain.u_assert.failures != 0) begin
      $display("%0d assertion failures on the output stream",
               u_axis_width_chain.u_assert.failures);
      errors += u_axis_width_chain.u_assert.failures;
    end
    $display("summary: %0d tests ok, %0d tests failing, %0d errors",
             pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_axis_width_chain -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Test passed"

/* source/adapter_pkg.sv */
`default_nettype none

package adapter_pkg;

  // transfer_in gathers narrow beats, transfer_out emits a held word or its slices
  typedef enum logic [1:0] {idle, transfer_in, transfer_out} adapter_state_t;

endpackage

`default_nettype wire

/* source/axis_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_adapter
  import stream_pkg::*, adapter_pkg::*;
#(
  parameter int IN_KEEP_WIDTH  = 4,
  parameter int OUT_KEEP_WIDTH = 1,
  localparam int IN_DATA_W     = IN_KEEP_WIDTH * $bits(byte_t),
  localparam int OUT_DATA_W    = OUT_KEEP_WIDTH * $bits(byte_t)
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire  [IN_DATA_W-1:0]       s_tdata,
  input  wire  [IN_KEEP_WIDTH-1:0]   s_tkeep,
  input  wire                        s_tvalid,
  output logic                       s_tready,
  input  wire                        s_tlast,
  input  wire                        s_tuser,
  output logic [OUT_DATA_W-1:0]      m_tdata,
  output logic [OUT_KEEP_WIDTH-1:0]  m_tkeep,
  output logic                       m_tvalid,
  input  wire                        m_tready,
  output logic                       m_tlast,
  output logic                       m_tuser
);

  localparam bit EXPAND     = OUT_KEEP_WIDTH > IN_KEEP_WIDTH;
  localparam int KEEP_W     = EXPAND ? OUT_KEEP_WIDTH : IN_KEEP_WIDTH;  // the wider side
  localparam int DATA_W     = KEEP_W * $bits(byte_t);
  localparam int CYCLES     = EXPAND ? OUT_KEEP_WIDTH / IN_KEEP_WIDTH :
                                       IN_KEEP_WIDTH / OUT_KEEP_WIDTH;
  localparam int SEG_KEEP_W = KEEP_W / CYCLES;
  localparam int SEG_DATA_W = SEG_KEEP_W * $bits(byte_t);
  localparam int CNT_W      = $clog2(CYCLES) + 1;  // widening counts up to CYCLES itself

  adapter_state_t            state_reg, state_next;
  logic [CNT_W-1:0]          cnt_reg, cnt_next;
  logic [DATA_W-1:0]         hold_data_reg, hold_data_next;
  logic [KEEP_W-1:0]         hold_keep_reg, hold_keep_next;
  logic                      hold_last_reg, hold_last_next;
  logic                      hold_user_reg, hold_user_next;
  logic                      s_tready_next;

  // beat offered by the core to the skid stage
  logic [OUT_DATA_W-1:0]     int_tdata;
  logic [OUT_KEEP_WIDTH-1:0] int_tkeep;
  logic                      int_tvalid, int_tlast, int_tuser;
  logic                      int_tready, int_tready_early;

  ////////////////////////////////////////////////////////////
  // core state machine
  ////////////////////////////////////////////////////////////

  if (CYCLES == 1) begin : g_pass
    always_comb begin
      state_next     = idle;
      cnt_next       = '0;
      hold_data_next = hold_data_reg;
      hold_keep_next = hold_keep_reg;
      hold_last_next = hold_last_reg;
      hold_user_next = hold_user_reg;
      s_tready_next  = int_tready_early;
      int_tdata      = s_tdata;
      int_tkeep      = s_tkeep;
      int_tvalid     = s_tvalid && s_tready;
      int_tlast      = s_tlast;
      int_tuser      = s_tuser;
    end
  end else if (EXPAND) begin : g_widen
    logic start;  // first narrow beat of a new word is taken

    always_comb begin
      state_next     = state_reg;
      cnt_next       = cnt_reg;
      hold_data_next = hold_data_reg;
      hold_keep_next = hold_keep_reg;
      hold_last_next = hold_last_reg;
      hold_user_next = hold_user_reg;
      s_tready_next  = 1'b0;
      start          = 1'b0;
      int_tdata      = hold_data_reg;
      int_tkeep      = hold_keep_reg;
      int_tvalid     = 1'b0;
      int_tlast      = hold_last_reg;
      int_tuser      = hold_user_reg;
      case (state_reg)
        idle: begin
          s_tready_next = 1'b1;
          start         = s_tready && s_tvalid;
        end
        transfer_in: begin
          s_tready_next = 1'b1;
          if (s_tready && s_tvalid) begin
            hold_data_next[cnt_reg*SEG_DATA_W +: SEG_DATA_W] = s_tdata;
            hold_keep_next[cnt_reg*SEG_KEEP_W +: SEG_KEEP_W] = s_tkeep;
            hold_last_next = s_tlast;
            hold_user_next = s_tuser;
            cnt_next       = cnt_reg + 1'b1;
            if (cnt_reg == CNT_W'(CYCLES - 1) || s_tlast) begin
              s_tready_next = int_tready_early;  // the word can leave as the next one starts
              state_next    = transfer_out;
            end
          end
        end
        default: begin
          int_tvalid = 1'b1;
          if (int_tready) begin
            s_tready_next = 1'b1;
            state_next    = idle;
            start         = s_tready && s_tvalid;
          end
        end
      endcase
      if (start) begin
        hold_data_next                   = '0;
        hold_data_next[SEG_DATA_W-1:0]   = s_tdata;
        hold_keep_next                   = '0;
        hold_keep_next[SEG_KEEP_W-1:0]   = s_tkeep;
        hold_last_next                   = s_tlast;
        hold_user_next                   = s_tuser;
        cnt_next                         = CNT_W'(1);
        s_tready_next                    = !s_tlast;
        state_next                       = s_tlast ? transfer_out : transfer_in;
      end
    end
  end else begin : g_narrow
    logic [DATA_W-1:0] cur_data;
    logic [KEEP_W-1:0] cur_keep;
    logic              cur_last, cur_user;
    logic [CNT_W-1:0]  seg;
    logic              last_seg;

    always_comb begin
      state_next     = state_reg;
      cnt_next       = cnt_reg;
      hold_data_next = hold_data_reg;
      hold_keep_next = hold_keep_reg;
      hold_last_next = hold_last_reg;
      hold_user_next = hold_user_reg;
      s_tready_next  = 1'b0;
      // idle slices the incoming word directly, later segments come from the held copy
      if (state_reg == idle) begin
        cur_data = s_tdata;
        cur_keep = s_tkeep;
        cur_last = s_tlast;
        cur_user = s_tuser;
        seg      = '0;
      end else begin
        cur_data = hold_data_reg;
        cur_keep = hold_keep_reg;
        cur_last = hold_last_reg;
        cur_user = hold_user_reg;
        seg      = cnt_reg;
      end
      if (seg == CNT_W'(CYCLES - 1)) begin
        last_seg = 1'b1;
      end else begin
        last_seg = cur_keep[seg*SEG_KEEP_W +: SEG_KEEP_W] != '1 ||
                   cur_keep[(seg+1)*SEG_KEEP_W +: SEG_KEEP_W] == '0;
      end
      int_tdata  = cur_data[seg*SEG_DATA_W +: SEG_DATA_W];
      int_tkeep  = cur_keep[seg*SEG_KEEP_W +: SEG_KEEP_W];
      int_tvalid = 1'b0;
      int_tlast  = cur_last && last_seg;  // last and user only on the final slice
      int_tuser  = cur_user && last_seg;
      case (state_reg)
        idle: begin
          s_tready_next = 1'b1;
          if (s_tready && s_tvalid) begin
            hold_data_next = s_tdata;
            hold_keep_next = s_tkeep;
            hold_last_next = s_tlast;
            hold_user_next = s_tuser;
            int_tvalid     = 1'b1;
            cnt_next       = int_tready ? CNT_W'(1) : '0;
            if (!last_seg || !int_tready) begin
              s_tready_next = 1'b0;
              state_next    = transfer_out;
            end
          end
        end
        default: begin
          int_tvalid = 1'b1;
          if (int_tready) begin
            cnt_next = cnt_reg + 1'b1;
            if (last_seg) begin
              s_tready_next = 1'b1;
              state_next    = idle;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg <= idle;
      cnt_reg   <= '0;
      s_tready  <= 1'b0;
    end else begin
      state_reg <= state_next;
      cnt_reg   <= cnt_next;
      s_tready  <= s_tready_next;
    end
  end

  always_ff @(posedge clk) begin
    hold_data_reg <= hold_data_next;
    hold_keep_reg <= hold_keep_next;
    hold_last_reg <= hold_last_next;
    hold_user_reg <= hold_user_next;
  end

  ////////////////////////////////////////////////////////////
  // output skid stage
  ////////////////////////////////////////////////////////////

  logic [OUT_DATA_W-1:0]     skid_tdata;
  logic [OUT_KEEP_WIDTH-1:0] skid_tkeep;
  logic                      skid_tvalid, skid_tlast, skid_tuser;
  logic                      load_out, load_skid, drain_skid;

  // predicts whether a core beat can be taken on the next cycle
  assign int_tready_early = m_tready || (!skid_tvalid && (!m_tvalid || !int_tvalid));

  assign load_out   = int_tready && (m_tready || !m_tvalid);
  assign load_skid  = int_tready && !m_tready && m_tvalid;  // in-flight beat parks here
  assign drain_skid = !int_tready && m_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      int_tready  <= 1'b0;
      m_tvalid    <= 1'b0;
      skid_tvalid <= 1'b0;
    end else begin
      int_tready <= int_tready_early;
      if (load_out) begin
        m_tvalid <= int_tvalid;
      end else if (drain_skid) begin
        m_tvalid <= skid_tvalid;
      end
      if (load_skid) begin
        skid_tvalid <= int_tvalid;
      end else if (drain_skid) begin
        skid_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      m_tdata <= int_tdata;
      m_tkeep <= int_tkeep;
      m_tlast <= int_tlast;
      m_tuser <= int_tuser;
    end else if (drain_skid) begin
      m_tdata <= skid_tdata;
      m_tkeep <= skid_tkeep;
      m_tlast <= skid_tlast;
      m_tuser <= skid_tuser;
    end
    if (load_skid) begin
      skid_tdata <= int_tdata;
      skid_tkeep <= int_tkeep;
      skid_tlast <= int_tlast;
      skid_tuser <= int_tuser;
    end
  end

endmodule

`default_nettype wire

/* source/axis_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH_DEFAULT
) (
  input  wire         clk,
  input  wire         rst,
  input  wire byte_t  s_tdata,
  input  wire         s_tkeep,
  input  wire         s_tvalid,
  output logic        s_tready,
  input  wire         s_tlast,
  input  wire         s_tuser,
  output byte_t       m_tdata,
  output logic        m_tkeep,
  output logic        m_tvalid,
  input  wire         m_tready,
  output logic        m_tlast,
  output logic        m_tuser
);

  localparam int ADDR_W = $clog2(DEPTH);

  byte_t           mem_data [DEPTH];
  logic            mem_keep [DEPTH];
  logic            mem_last [DEPTH];
  logic            mem_user [DEPTH];
  logic [ADDR_W:0] wr_ptr, rd_ptr;  // extra bit tells full from empty
  logic            full, empty;
  logic            wr_en, rd_en, out_load, bypass;

  assign full  = wr_ptr[ADDR_W] != rd_ptr[ADDR_W] &&
                 wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0];
  assign empty = wr_ptr == rd_ptr;

  assign s_tready = !full;
  assign wr_en    = s_tvalid && !full;
  assign out_load = m_tready || !m_tvalid;       // head register free this cycle
  assign rd_en    = out_load && !empty;
  assign bypass   = out_load && empty && wr_en;  // write goes straight to the head

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      m_tvalid <= 1'b0;
    end else begin
      if (wr_en && !bypass) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (out_load) begin
        m_tvalid <= rd_en || bypass;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !bypass) begin
      mem_data[wr_ptr[ADDR_W-1:0]] <= s_tdata;
      mem_keep[wr_ptr[ADDR_W-1:0]] <= s_tkeep;
      mem_last[wr_ptr[ADDR_W-1:0]] <= s_tlast;
      mem_user[wr_ptr[ADDR_W-1:0]] <= s_tuser;
    end
    if (rd_en) begin
      m_tdata <= mem_data[rd_ptr[ADDR_W-1:0]];
      m_tkeep <= mem_keep[rd_ptr[ADDR_W-1:0]];
      m_tlast <= mem_last[rd_ptr[ADDR_W-1:0]];
      m_tuser <= mem_user[rd_ptr[ADDR_W-1:0]];
    end else if (bypass) begin
      m_tdata <= s_tdata;
      m_tkeep <= s_tkeep;
      m_tlast <= s_tlast;
      m_tuser <= s_tuser;
    end
  end

endmodule

`default_nettype wire

/* source/axis_width_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_width_chain
  import stream_pkg::*;
#(
  parameter int IN_BYTES   = stream_pkg::IN_BYTES,
  parameter int OUT_BYTES  = stream_pkg::OUT_BYTES,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
  input  wire            clk,
  input  wire            rst,
  input  wire in_data_t  s_axis_tdata,
  input  wire in_keep_t  s_axis_tkeep,
  input  wire            s_axis_tvalid,
  output logic           s_axis_tready,
  input  wire            s_axis_tlast,
  input  wire            s_axis_tuser,
  output out_data_t      m_axis_tdata,
  output out_keep_t      m_axis_tkeep,
  output logic           m_axis_tvalid,
  input  wire            m_axis_tready,
  output logic           m_axis_tlast,
  output logic           m_axis_tuser
);

  // byte stream between the narrowing adapter and the FIFO
  byte_t mid_tdata;
  logic  mid_tkeep, mid_tvalid, mid_tready, mid_tlast, mid_tuser;

  // byte stream between the FIFO and the widening adapter
  byte_t buf_tdata;
  logic  buf_tkeep, buf_tvalid, buf_tready, buf_tlast, buf_tuser;

  axis_adapter #(.IN_KEEP_WIDTH(IN_BYTES), .OUT_KEEP_WIDTH(MID_BYTES)) u_narrow (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_axis_tdata),
    .s_tkeep  (s_axis_tkeep),
    .s_tvalid (s_axis_tvalid),
    .s_tready (s_axis_tready),
    .s_tlast  (s_axis_tlast),
    .s_tuser  (s_axis_tuser),
    .m_tdata  (mid_tdata),
    .m_tkeep  (mid_tkeep),
    .m_tvalid (mid_tvalid),
    .m_tready (mid_tready),
    .m_tlast  (mid_tlast),
    .m_tuser  (mid_tuser)
  );

  axis_fifo #(.DEPTH(FIFO_DEPTH)) u_buffer (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (mid_tdata),
    .s_tkeep  (mid_tkeep),
    .s_tvalid (mid_tvalid),
    .s_tready (mid_tready),
    .s_tlast  (mid_tlast),
    .s_tuser  (mid_tuser),
    .m_tdata  (buf_tdata),
    .m_tkeep  (buf_tkeep),
    .m_tvalid (buf_tvalid),
    .m_tready (buf_tready),
    .m_tlast  (buf_tlast),
    .m_tuser  (buf_tuser)
  );

  axis_adapter #(.IN_KEEP_WIDTH(MID_BYTES), .OUT_KEEP_WIDTH(OUT_BYTES)) u_widen (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (buf_tdata),
    .s_tkeep  (buf_tkeep),
    .s_tvalid (buf_tvalid),
    .s_tready (buf_tready),
    .s_tlast  (buf_tlast),
    .s_tuser  (buf_tuser),
    .m_tdata  (m_axis_tdata),
    .m_tkeep  (m_axis_tkeep),
    .m_tvalid (m_axis_tvalid),
    .m_tready (m_axis_tready),
    .m_tlast  (m_axis_tlast),
    .m_tuser  (m_axis_tuser)
  );

endmodule

`default_nettype wire

/* source/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  // lane counts of the chain as built by default
  localparam int IN_BYTES  = 4;
  localparam int MID_BYTES = 1;  // the buffer between the adapters is byte wide
  localparam int OUT_BYTES = 2;

  localparam int FIFO_DEPTH_DEFAULT = 16;

  typedef logic [7:0]              byte_t;
  typedef logic [IN_BYTES*8-1:0]   in_data_t;
  typedef logic [IN_BYTES-1:0]     in_keep_t;
  typedef logic [OUT_BYTES*8-1:0]  out_data_t;
  typedef logic [OUT_BYTES-1:0]    out_keep_t;

endpackage

`default_nettype wire

/* vlog.f */
source/stream_pkg.sv
source/adapter_pkg.sv
source/axis_adapter.sv
source/axis_fifo.sv
source/axis_width_chain.sv
dv/axis_width_chain_assert.sv
dv/tb_axis_width_chain.sv
